// File: Makefile
SIM       := verilator
TOP       := tb_mcr_input
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert -sv --top-module $(TOP) -Mdir $(OBJ_DIR)
RUN_FLAGS := +verilator+error+limit+100
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mcr_input_checker.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module mcr_input_checker (
	input logic                clk_sys,
	input logic                rst_n_i,
	input mcr_pkg::game_id_e   game_i,
	input mcr_pkg::cfg_t       cfg_i,
	input mcr_pkg::player_t    p1_i,
	input mcr_pkg::player_t    p2_i,
	input mcr_pkg::sys_ctrl_t  sys_i,
	input mcr_pkg::mouse_t     mouse_i,
	input logic                vsync_i,
	input mcr_pkg::dl_t        dl_i,
	input mcr_pkg::in_ports_t  ports_o,
	input logic                core_reset_o,
	input logic [1:0]          port_req_o,
	input logic                rom_wr_o,
	input logic                cmos_wr_o,
	input logic                led_o
);

	logic                    failed; // Any assertion has fired
	logic signed [10:0]      wx, wy; // Mouse deltas sign extend into these
	logic signed [9:0]       kx, ky;
	logic [1:0]              mbtn;
	logic [6:0]              ang1, ang2;
	logic                    vs_q, act_q, wr_q, loaded, core_rst;
	logic [1:0]              req;
	logic signed [8:0]       mvx, mvy; // KROOZR moves keep the 9-bit mouse width
	logic                    s1l, s1r, s2l, s2r;
	logic                    tron;
	mcr_pkg::in_ports_t      exp_ports;

	initial failed = 1'b0;

	// Held position if the step leaves the 10-bit signed range
	function automatic logic signed [9:0] clamp_step(logic signed [9:0] pos, int delta);
		int cand;
		cand = pos + delta;
		if (cand > 511 || cand < -512) return pos;
		return 10'(cand);
	endfunction

	function automatic logic [6:0] spin_step(logic [6:0] a, logic l, logic r, logic fast);
		int s;
		s = fast ? `MCR_SPIN_STEP_HI : `MCR_SPIN_STEP_LO;
		if (l == r) return a; // Both or neither pressed
		return l ? 7'(a - s) : 7'(a + s);
	endfunction

	assign mvx  = cfg_i.rotate ? -mouse_i.dy : mouse_i.dx;
	assign mvy  = cfg_i.rotate ? mouse_i.dx : mouse_i.dy;
	assign tron = (game_i == mcr_pkg::GAME_TRON);
	assign s1l  = p1_i.up | p1_i.left;
	assign s1r  = p1_i.down | p1_i.right;
	assign s2l  = p2_i.up | p2_i.left | (tron & p1_i.fire_b);
	assign s2r  = p2_i.down | p2_i.right | (tron & p1_i.fire_c);

	// ====================
	// Reference models
	// ====================
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			{wx, wy, kx, ky, mbtn, ang1, ang2} <= '0;
			{vs_q, act_q, wr_q, loaded, req}   <= '0;
			core_rst <= 1'b1;
		end else begin
			vs_q     <= vsync_i;
			act_q    <= dl_i.active;
			wr_q     <= dl_i.wr;
			core_rst <= cfg_i.reset_req | dl_i.active | ~loaded;
			if (act_q && !dl_i.active) loaded <= 1'b1;
			if (dl_i.active && dl_i.wr && !wr_q && dl_i.index == `MCR_IDX_ROM) begin
				req <= ~req;
			end
			if (mouse_i.strobe) begin
				mbtn <= mouse_i.buttons;
				wx   <= cfg_i.rotate ? wx - mouse_i.dy : wx + mouse_i.dx;
				wy   <= cfg_i.rotate ? wy + mouse_i.dx : wy + mouse_i.dy;
				kx   <= clamp_step(kx, -int'(mvx));
				ky   <= clamp_step(ky, int'(mvy));
			end
			if (core_rst) begin
				ang1 <= '0;
				ang2 <= '0;
			end else if (vsync_i && !vs_q) begin
				ang1 <= spin_step(ang1, s1l, s1r, cfg_i.spin_fast);
				ang2 <= spin_step(ang2, s2l, s2r, cfg_i.spin_fast);
			end
		end
	end

	always_comb begin
		logic x_bit;
		x_bit     = 1'b0;
		exp_ports = '{default: 8'hFF};
		case (game_i)
			mcr_pkg::GAME_SHOLLOW: begin
				exp_ports.p1 = ~{p2_i.fire_a, p2_i.fire_b, p2_i.right, p2_i.left,
					p1_i.fire_a, p1_i.fire_b, p1_i.right, p1_i.left};
				exp_ports.p3 = 8'hFD;
			end
			mcr_pkg::GAME_TRON: begin
				x_bit        = p1_i.fire_a;
				exp_ports.p1 = {1'b1, ~ang2};
				exp_ports.p4 = {1'b1, ~ang2};
				exp_ports.p2 = ~{p1_i.down, p1_i.up, p1_i.right, p1_i.left,
					p1_i.down, p1_i.up, p1_i.right, p1_i.left};
				exp_ports.p3 = {~p1_i.fire_a, 4'b1111, ~cfg_i.opt8, 2'b01};
			end
			mcr_pkg::GAME_TWOTIGER: begin
				x_bit        = sys_i.start3;
				exp_ports.p1 = {1'b1, ~ang1};
				exp_ports.p2 = {4'hF, ~p2_i.fire_b, ~p2_i.fire_a, ~p1_i.fire_b, ~p1_i.fire_a};
				exp_ports.p4 = {1'b1, ~ang2};
			end
			mcr_pkg::GAME_WACKO: begin
				exp_ports.p1 = wx[10:3];
				exp_ports.p2 = wy[10:3];
				exp_ports.p3 = 8'hBF;
				exp_ports.p4 = ~{p2_i.up, p2_i.down, p2_i.left, p2_i.right,
					p1_i.up, p1_i.down, p1_i.left, p1_i.right};
			end
			mcr_pkg::GAME_KROOZR: begin
				x_bit        = p1_i.fire_a | mbtn[0];
				exp_ports.p1 = ~{p1_i.fire_b | mbtn[1], ang1[6], 3'b111, ang1[5:3]};
				exp_ports.p2 = {kx[9], kx[9], kx[7:2]};
				exp_ports.p3 = 8'hBF;
				exp_ports.p4 = {ky[9], ky[9], ky[7:2]};
			end
			mcr_pkg::GAME_DOMINO: begin
				x_bit        = p1_i.fire_a;
				exp_ports.p1 = {4'hF, ~p1_i.down, ~p1_i.up, ~p1_i.right, ~p1_i.left};
				exp_ports.p2 = {3'b111, ~p2_i.fire_a, ~p2_i.down, ~p2_i.up, ~p2_i.right,
					~p2_i.left};
				exp_ports.p3 = {6'b101111, ~cfg_i.opt9, ~cfg_i.opt8};
			end
			default: x_bit = 1'b0;
		endcase
		if (game_i <= mcr_pkg::GAME_DOMINO) begin
			exp_ports.p0 = ~{sys_i.service, 1'b0, sys_i.tilt, x_bit,
				sys_i.start2, sys_i.start1, sys_i.coin2, sys_i.coin1};
		end
	end

	// ====================
	// Assertions
	// ====================
	a_p0: assert property (@(posedge clk_sys) disable iff (!rst_n_i) ports_o.p0 == exp_ports.p0)
		else begin
			failed = 1'b1;
			$error("MISMATCH ports_o.p0: got %h exp %h",
				$sampled(ports_o.p0), $sampled(exp_ports.p0));
		end
	a_p1: assert property (@(posedge clk_sys) disable iff (!rst_n_i) ports_o.p1 == exp_ports.p1)
		else begin
			failed = 1'b1;
			$error("MISMATCH ports_o.p1: got %h exp %h",
				$sampled(ports_o.p1), $sampled(exp_ports.p1));
		end
	a_p2: assert property (@(posedge clk_sys) disable iff (!rst_n_i) ports_o.p2 == exp_ports.p2)
		else begin
			failed = 1'b1;
			$error("MISMATCH ports_o.p2: got %h exp %h",
				$sampled(ports_o.p2), $sampled(exp_ports.p2));
		end
	a_p3: assert property (@(posedge clk_sys) disable iff (!rst_n_i) ports_o.p3 == exp_ports.p3)
		else begin
			failed = 1'b1;
			$error("MISMATCH ports_o.p3: got %h exp %h",
				$sampled(ports_o.p3), $sampled(exp_ports.p3));
		end
	a_p4: assert property (@(posedge clk_sys) disable iff (!rst_n_i) ports_o.p4 == exp_ports.p4)
		else begin
			failed = 1'b1;
			$error("MISMATCH ports_o.p4: got %h exp %h",
				$sampled(ports_o.p4), $sampled(exp_ports.p4));
		end

	a_core_reset: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		core_reset_o == core_rst)
		else begin
			failed = 1'b1;
			$error("MISMATCH core_reset_o: got %h exp %h",
				$sampled(core_reset_o), $sampled(core_rst));
		end
	a_req: assert property (@(posedge clk_sys) disable iff (!rst_n_i) port_req_o == req)
		else begin
			failed = 1'b1;
			$error("MISMATCH port_req_o: got %h exp %h",
				$sampled(port_req_o), $sampled(req));
		end
	a_wr: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		{rom_wr_o, cmos_wr_o} == {dl_i.wr && dl_i.index == `MCR_IDX_ROM,
			dl_i.wr && dl_i.index == `MCR_IDX_CMOS})
		else begin
			failed = 1'b1;
			$error("MISMATCH rom_wr_o/cmos_wr_o: got %h idx %h wr %h",
				$sampled({rom_wr_o, cmos_wr_o}), $sampled(dl_i.index), $sampled(dl_i.wr));
		end
	a_led: assert property (@(posedge clk_sys) disable iff (!rst_n_i) led_o == !dl_i.active)
		else begin
			failed = 1'b1;
			$error("MISMATCH led_o: got %h exp %h",
				$sampled(led_o), $sampled(!dl_i.active));
		end

endmodule

// File: dv/tb_mcr_input.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module tb_mcr_input;

	localparam int BLOCK_CYCLES = 200;
	localparam int BYTE_CYCLES  = 3;  // Write high for one, low for two
	localparam int ROM_BYTES    = 16;
	localparam int CMOS_BYTES   = 4;
	localparam int ROUND_CYCLES = 7 * BLOCK_CYCLES + (ROM_BYTES + CMOS_BYTES) * BYTE_CYCLES + 5;
	localparam int RUN_CYCLES   = 3 + 2 * ROUND_CYCLES;
	localparam int MAX_CYCLES   = RUN_CYCLES + 2000;

	logic                clk_sys;
	logic                rst_n;
	mcr_pkg::game_id_e   game;
	mcr_pkg::cfg_t       cfg;
	mcr_pkg::player_t    p1, p2;
	mcr_pkg::sys_ctrl_t  sys_ctrl;
	mcr_pkg::mouse_t     mouse;
	logic                vsync;
	mcr_pkg::dl_t        dl;
	mcr_pkg::in_ports_t  ports;
	logic                core_reset;
	logic [1:0]          port_req;
	logic                rom_wr, cmos_wr, led;
	logic [31:0]         lfsr;
	int                  cycles;

	mcr_input_top UUT (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n),
		.game_i       (game),
		.cfg_i        (cfg),
		.p1_i         (p1),
		.p2_i         (p2),
		.sys_i        (sys_ctrl),
		.mouse_i      (mouse),
		.vsync_i      (vsync),
		.dl_i         (dl),
		.ports_o      (ports),
		.core_reset_o (core_reset),
		.port_req_o   (port_req),
		.rom_wr_o     (rom_wr),
		.cmos_wr_o    (cmos_wr),
		.led_o        (led)
	);

	bind mcr_input_top mcr_input_checker u_chk (.*);

	always #2 clk_sys = ~clk_sys;

	// Galois LFSR, right shifting
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic stop_on_failure(string why);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", why);
	endtask

	// New random controls every falling edge
	task automatic step_cycle();
		@(negedge clk_sys);
		p1             = 7'(take_bits(7));
		p2             = 7'(take_bits(7));
		sys_ctrl       = 7'(take_bits(7));
		cfg.rotate     = take_bits(1) != 0;
		cfg.spin_fast  = take_bits(1) != 0;
		cfg.reset_req  = take_bits(4) == 32'hF; // Rare, so spinners get to move
		cfg.opt8       = take_bits(1) != 0;
		cfg.opt9       = take_bits(1) != 0;
		mouse.dx       = 9'(take_bits(9));
		mouse.dy       = 9'(take_bits(9));
		mouse.buttons  = 2'(take_bits(2));
		mouse.strobe   = take_bits(1) != 0;
		vsync          = (cycles % 10 == 0);
	endtask

	task automatic download_bytes(logic [7:0] index, int count);
		for (int i = 0; i < count; i++) begin
			for (int c = 0; c < BYTE_CYCLES; c++) begin
				step_cycle();
				dl.active = 1'b1;
				dl.wr     = (c == 0);
				dl.index  = index;
				dl.addr   = 24'(i);
				dl.data   = 8'(take_bits(8));
			end
		end
	endtask

	// All games, idle id, then one ROM and CMOS download
	task automatic run_round();
		for (int g = 0; g <= 6; g++) begin
			game = mcr_pkg::game_id_e'(g == 6 ? 7 : g);
			repeat (BLOCK_CYCLES) step_cycle();
		end
		download_bytes(`MCR_IDX_ROM, ROM_BYTES);
		download_bytes(`MCR_IDX_CMOS, CMOS_BYTES);
		step_cycle();
		dl = '0;
		repeat (4) step_cycle();
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) stop_on_failure("Timeout, the run did not reach its end");
	end

	always @(negedge clk_sys) begin
		if (UUT.u_chk.failed) stop_on_failure("A checker assertion failed");
	end

	initial begin
		clk_sys  = 1'b0;
		rst_n    = 1'b0;
		lfsr     = 32'hc855_2504;
		game     = mcr_pkg::GAME_SHOLLOW;
		cfg      = '0;
		p1       = '0;
		p2       = '0;
		sys_ctrl = '0;
		mouse    = '0;
		vsync    = 1'b0;
		dl       = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		run_round(); // Core still held in reset, spinners stay cleared
		run_round();
		if (UUT.u_chk.failed) begin
			stop_on_failure("A checker assertion failed");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: hdl/input_port_mux.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module input_port_mux (
	input  mcr_pkg::game_id_e       game_i,
	input  mcr_pkg::cfg_t           cfg_i,
	input  mcr_pkg::player_t        p1_i,
	input  mcr_pkg::player_t        p2_i,
	input  mcr_pkg::sys_ctrl_t      sys_i,
	input  mcr_pkg::track_t         track_i,
	input  logic [1:0]              mbtn_i,   // Latched mouse buttons
	input  logic [`MCR_ANGLE_W-1:0] angle1_i,
	input  logic [`MCR_ANGLE_W-1:0] angle2_i,
	output logic                    spin1_l_o,
	output logic                    spin1_r_o,
	output logic                    spin2_l_o,
	output logic                    spin2_r_o,
	output mcr_pkg::in_ports_t      ports_o
);

	logic is_tron;
	logic known;   // Game id is one of the six
	logic x_bit;   // Per-game bit 4 of the system byte

	assign is_tron = (game_i == mcr_pkg::GAME_TRON);

	// ====================
	// Spinner buttons
	// ====================
	assign spin1_l_o = p1_i.left | p1_i.up;
	assign spin1_r_o = p1_i.right | p1_i.down;
	assign spin2_l_o = p2_i.left | p2_i.up | (is_tron & p1_i.fire_b);
	assign spin2_r_o = p2_i.right | p2_i.down | (is_tron & p1_i.fire_c);

	// ====================
	// Game ports
	// ====================
	always_comb begin
		ports_o = '{default: 8'hFF};
		known   = 1'b1;
		x_bit   = 1'b0;
		case (game_i)
			mcr_pkg::GAME_SHOLLOW: begin
				ports_o.p1 = ~{p2_i.fire_a, p2_i.fire_b, p2_i.right, p2_i.left,
					p1_i.fire_a, p1_i.fire_b, p1_i.right, p1_i.left};
				ports_o.p3 = 8'hFD;
			end
			mcr_pkg::GAME_TRON: begin
				x_bit      = p1_i.fire_a;
				ports_o.p1 = ~{1'b0, angle2_i};
				ports_o.p2 = ~{2{p1_i.down, p1_i.up, p1_i.right, p1_i.left}};
				ports_o.p3 = ~{p1_i.fire_a, 4'b0000, cfg_i.opt8, 2'b10};
				ports_o.p4 = ~{1'b0, angle2_i};
			end
			mcr_pkg::GAME_TWOTIGER: begin
				x_bit      = sys_i.start3;
				ports_o.p1 = ~{1'b0, angle1_i};
				ports_o.p2 = ~{4'b0000, p2_i.fire_b, p2_i.fire_a, p1_i.fire_b, p1_i.fire_a};
				ports_o.p4 = ~{1'b0, angle2_i};
			end
			mcr_pkg::GAME_WACKO: begin
				ports_o.p1 = track_i.wacko_x[10:3];
				ports_o.p2 = track_i.wacko_y[10:3];
				ports_o.p3 = 8'hBF;
				ports_o.p4 = ~{p2_i.up, p2_i.down, p2_i.left, p2_i.right,
					p1_i.up, p1_i.down, p1_i.left, p1_i.right};
			end
			mcr_pkg::GAME_KROOZR: begin
				x_bit      = p1_i.fire_a | mbtn_i[0];
				ports_o.p1 = ~{p1_i.fire_b | mbtn_i[1], angle1_i[6], 3'b111, angle1_i[5:3]};
				ports_o.p2 = {{2{track_i.kroozr_x[9]}}, track_i.kroozr_x[7:2]}; // Not inverted
				ports_o.p3 = 8'hBF;
				ports_o.p4 = {{2{track_i.kroozr_y[9]}}, track_i.kroozr_y[7:2]};
			end
			mcr_pkg::GAME_DOMINO: begin
				x_bit      = p1_i.fire_a;
				ports_o.p1 = ~{4'b0000, p1_i.down, p1_i.up, p1_i.right, p1_i.left};
				ports_o.p2 = ~{3'b000, p2_i.fire_a, p2_i.down, p2_i.up, p2_i.right, p2_i.left};
				ports_o.p3 = ~{6'b010000, cfg_i.opt9, cfg_i.opt8};
			end
			default: known = 1'b0; // Idle, all ports FF
		endcase

		// Common system byte
		if (known) begin
			ports_o.p0 = ~{sys_i.service, 1'b0, sys_i.tilt, x_bit,
				sys_i.start2, sys_i.start1, sys_i.coin2, sys_i.coin1};
		end
	end

endmodule

// File: hdl/load_reset_ctrl.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module load_reset_ctrl (
	input  logic         clk_sys,
	input  logic         rst_n_i,
	input  mcr_pkg::dl_t dl_i,
	input  logic         reset_req_i,
	output logic         core_reset_o,
	output logic [1:0]   port_req_o,  // Toggle per ROM byte
	output logic         rom_wr_o,
	output logic         cmos_wr_o
);

	logic wr_q;
	logic active_q;
	logic rom_loaded;
	logic is_rom;

	assign is_rom    = (dl_i.index == `MCR_IDX_ROM);
	assign rom_wr_o  = dl_i.wr & is_rom;
	assign cmos_wr_o = dl_i.wr & (dl_i.index == `MCR_IDX_CMOS);

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_q         <= 1'b0;
			active_q     <= 1'b0;
			rom_loaded   <= 1'b0;
			core_reset_o <= 1'b1; // Core held until the first load
			port_req_o   <= '0;
		end else begin
			wr_q     <= dl_i.wr;
			active_q <= dl_i.active;
			if (dl_i.active && dl_i.wr && !wr_q && is_rom) begin
				port_req_o <= ~port_req_o;
			end
			if (active_q && !dl_i.active) rom_loaded <= 1'b1; // End of download
			core_reset_o <= reset_req_i | dl_i.active | ~rom_loaded;
		end
	end

endmodule

// File: hdl/mcr_consts.svh
`ifndef MCR_CONSTS_SVH
`define MCR_CONSTS_SVH

// ====================
// Widths
// ====================
`define MCR_GAME_W        7
`define MCR_ANGLE_W       7
`define MCR_WACKO_POS_W   11
`define MCR_KROOZR_POS_W  10

// Spinner steps per vsync
`define MCR_SPIN_STEP_LO  1
`define MCR_SPIN_STEP_HI  2

// Download indices
`define MCR_IDX_ROM       8'h00
`define MCR_IDX_CMOS      8'hFF

// ====================
// Game ids
// ====================
`define MCR_ID_SHOLLOW    0
`define MCR_ID_TRON       1
`define MCR_ID_TWOTIGER   2
`define MCR_ID_WACKO      3
`define MCR_ID_KROOZR     4
`define MCR_ID_DOMINO     5

`endif

// File: hdl/mcr_input_top.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module mcr_input_top (
	input  logic                clk_sys,
	input  logic                rst_n_i,
	input  mcr_pkg::game_id_e   game_i,
	input  mcr_pkg::cfg_t       cfg_i,
	input  mcr_pkg::player_t    p1_i,
	input  mcr_pkg::player_t    p2_i,
	input  mcr_pkg::sys_ctrl_t  sys_i,
	input  mcr_pkg::mouse_t     mouse_i,
	input  logic                vsync_i,
	input  mcr_pkg::dl_t        dl_i,
	output mcr_pkg::in_ports_t  ports_o,
	output logic                core_reset_o,
	output logic [1:0]          port_req_o,
	output logic                rom_wr_o,
	output logic                cmos_wr_o,
	output logic                led_o
);

	mcr_pkg::track_t         track;
	logic [1:0]              mbtn;
	logic                    spin1_l, spin1_r, spin2_l, spin2_r;
	logic [`MCR_ANGLE_W-1:0] angle1, angle2;

	assign led_o = ~dl_i.active; // Lit while idle

	mouse_tracker u_mouse (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.mouse_i   (mouse_i),
		.rotate_i  (cfg_i.rotate),
		.track_o   (track),
		.buttons_o (mbtn)
	);

	// ====================
	// Spinners
	// ====================
	spinner u_spin1 (
		.clk_sys (clk_sys),      .rst_n_i (rst_n_i),      .clr_i   (core_reset_o),
		.fast_i  (cfg_i.spin_fast), .left_i (spin1_l),    .right_i (spin1_r),
		.vsync_i (vsync_i),      .angle_o (angle1)
	);

	spinner u_spin2 (
		.clk_sys (clk_sys),      .rst_n_i (rst_n_i),      .clr_i   (core_reset_o),
		.fast_i  (cfg_i.spin_fast), .left_i (spin2_l),    .right_i (spin2_r),
		.vsync_i (vsync_i),      .angle_o (angle2)
	);

	input_port_mux u_mux (
		.game_i    (game_i),  .cfg_i     (cfg_i),   .p1_i      (p1_i),
		.p2_i      (p2_i),    .sys_i     (sys_i),   .track_i   (track),
		.mbtn_i    (mbtn),    .angle1_i  (angle1),  .angle2_i  (angle2),
		.spin1_l_o (spin1_l), .spin1_r_o (spin1_r),
		.spin2_l_o (spin2_l), .spin2_r_o (spin2_r),
		.ports_o   (ports_o)
	);

	load_reset_ctrl u_load (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.dl_i         (dl_i),
		.reset_req_i  (cfg_i.reset_req),
		.core_reset_o (core_reset_o),
		.port_req_o   (port_req_o),
		.rom_wr_o     (rom_wr_o),
		.cmos_wr_o    (cmos_wr_o)
	);

endmodule

// File: hdl/mcr_pkg.sv
`include "mcr_consts.svh"

package mcr_pkg;

	// Unlisted codes fall through to the idle default
	typedef enum logic [`MCR_GAME_W-1:0] {
		GAME_SHOLLOW  = `MCR_GAME_W'(`MCR_ID_SHOLLOW),
		GAME_TRON     = `MCR_GAME_W'(`MCR_ID_TRON),
		GAME_TWOTIGER = `MCR_GAME_W'(`MCR_ID_TWOTIGER),
		GAME_WACKO    = `MCR_GAME_W'(`MCR_ID_WACKO),
		GAME_KROOZR   = `MCR_GAME_W'(`MCR_ID_KROOZR),
		GAME_DOMINO   = `MCR_GAME_W'(`MCR_ID_DOMINO)
	} game_id_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
	} player_t; // Active high

	typedef struct packed {
		logic tilt;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic start3;
		logic service;
	} sys_ctrl_t;

	// Menu switches
	typedef struct packed {
		logic rotate;
		logic spin_fast;
		logic reset_req;
		logic opt8;
		logic opt9;
	} cfg_t;

	typedef struct packed {
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [1:0]        buttons;
		logic              strobe; // One-cycle pulse per report
	} mouse_t;

	typedef struct packed {
		logic        active;
		logic        wr;
		logic [7:0]  index;
		logic [23:0] addr;
		logic [7:0]  data;
	} dl_t;

	typedef struct packed {
		logic [`MCR_WACKO_POS_W-1:0]  wacko_x;
		logic [`MCR_WACKO_POS_W-1:0]  wacko_y;
		logic [`MCR_KROOZR_POS_W-1:0] kroozr_x;
		logic [`MCR_KROOZR_POS_W-1:0] kroozr_y;
	} track_t;

	typedef struct packed {
		logic [7:0] p0;
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p3;
		logic [7:0] p4;
	} in_ports_t; // Active low toward the game CPU

endpackage

// File: hdl/mouse_tracker.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module mouse_tracker (
	input  logic            clk_sys,
	input  logic            rst_n_i,
	input  mcr_pkg::mouse_t mouse_i,
	input  logic            rotate_i,
	output mcr_pkg::track_t track_o,
	output logic [1:0]      buttons_o
);

	logic signed [`MCR_WACKO_POS_W-1:0]  wx, wy;   // WACKO, free wrapping
	logic signed [`MCR_WACKO_POS_W-1:0]  dx_w, dy_w;
	logic signed [`MCR_KROOZR_POS_W-1:0] kx, ky;   // KROOZR, held at the edges
	logic signed [`MCR_KROOZR_POS_W-1:0] kx_new, ky_new;
	logic signed [8:0]                   move_x, move_y;
	logic                                kx_ovf, ky_ovf;

	assign dx_w = mouse_i.dx; // Sign extends
	assign dy_w = mouse_i.dy;

	// Rotated cabinet swaps the axes
	assign move_x = rotate_i ? -mouse_i.dy : mouse_i.dx;
	assign move_y = rotate_i ? mouse_i.dx : mouse_i.dy;
	assign kx_new = kx - move_x;
	assign ky_new = ky + move_y;

	// Signed overflow of the candidate, subtract on x and add on y
	assign kx_ovf = (move_x[8] & ~kx[9] & kx_new[9]) | (~move_x[8] & kx[9] & ~kx_new[9]);
	assign ky_ovf = (move_y[8] & ky[9] & ~ky_new[9]) | (~move_y[8] & ~ky[9] & ky_new[9]);

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wx        <= '0;
			wy        <= '0;
			kx        <= '0;
			ky        <= '0;
			buttons_o <= '0;
		end else if (mouse_i.strobe) begin
			buttons_o <= mouse_i.buttons;
			if (rotate_i) begin
				wx <= wx - dy_w;
				wy <= wy + dx_w;
			end else begin
				wx <= wx + dx_w;
				wy <= wy + dy_w;
			end
			if (!kx_ovf) kx <= kx_new;
			if (!ky_ovf) ky <= ky_new;
		end
	end

	assign track_o = '{wacko_x: wx, wacko_y: wy, kroozr_x: kx, kroozr_y: ky};

endmodule

// File: hdl/spinner.sv
`timescale 1ns/10ps
`include "mcr_consts.svh"

module spinner (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  logic                    clr_i,   // Core reset
	input  logic                    fast_i,
	input  logic                    left_i,
	input  logic                    right_i,
	input  logic                    vsync_i,
	output logic [`MCR_ANGLE_W-1:0] angle_o
);

	logic                    vsync_q;
	logic                    vsync_rise;
	logic [`MCR_ANGLE_W-1:0] step;

	assign vsync_rise = vsync_i & ~vsync_q;
	assign step = fast_i ? `MCR_ANGLE_W'(`MCR_SPIN_STEP_HI) : `MCR_ANGLE_W'(`MCR_SPIN_STEP_LO);

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vsync_q <= 1'b0;
		end else begin
			vsync_q <= vsync_i;
		end
	end

	// One step per frame, wraps modulo 128
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			angle_o <= '0;
		end else if (clr_i) begin
			angle_o <= '0;
		end else if (vsync_rise) begin
			if (left_i && !right_i) begin
				angle_o <= angle_o - step;
			end else if (right_i && !left_i) begin
				angle_o <= angle_o + step;
			end
		end
	end

endmodule

// File: sim.f
+incdir+hdl
hdl/mcr_pkg.sv
hdl/mouse_tracker.sv
hdl/spinner.sv
hdl/input_port_mux.sv
hdl/load_reset_ctrl.sv
hdl/mcr_input_top.sv
dv/mcr_input_checker.sv
dv/tb_mcr_input.sv
